//--- uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// system clock in Hz, 40 ns period
`define UART_CLOCK_FREQ 25_000_000

// bit rate, 16 clocks per bit at the clock above
`define UART_BAUD_RATE 1_562_500

// entries per FIFO, power of two only
`define UART_FIFO_DEPTH 4

// register map on the 2-bit word address
`define UART_ADDR_DATA 2'd0
`define UART_ADDR_STATUS 2'd1

// reads of an unmapped address return zero
`define UART_READ_NONE 8'h00

`endif

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

  // one character as it leaves the receiver
  typedef struct packed {
    logic [7:0] data;
    // stop bit was sampled low
    logic       frame_err;
  } rx_char_t;

  // status register bit positions
  localparam int STATUS_TX_EMPTY = 0;
  localparam int STATUS_TX_FULL = 1;
  localparam int STATUS_RX_EMPTY = 2;
  localparam int STATUS_RX_FULL = 3;
  // sticky bits, cleared by writing a one
  localparam int STATUS_FRAME_ERR = 4;
  localparam int STATUS_OVERRUN = 5;

endpackage

`default_nettype wire

//--- uart_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     full,
  output logic     empty
);
  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // payload storage indexed by the low pointer bits
  payload_t mem [DEPTH];

  // one extra wrap bit tells full from empty
  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] rd_ptr;
  logic                do_push;
  logic                do_pop;

  // a push when full or a pop when empty is dropped
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  assign empty = wr_ptr == rd_ptr;
  assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  // head is read straight from the array
  assign head = mem[rd_ptr[ADDR_WIDTH-1:0]];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

// 8 data bits, no parity, one stop bit, lsb first
module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] data,
  input  logic       tx_en,
  output logic       tx_ready,
  output logic       tx
);
  localparam int CLOCKS_PER_BIT = `UART_CLOCK_FREQ / `UART_BAUD_RATE;
  localparam int CLK_COUNT_WIDTH = $clog2(CLOCKS_PER_BIT);

  localparam logic [CLK_COUNT_WIDTH-1:0] CLK_COUNT_MAX =
    CLK_COUNT_WIDTH'(CLOCKS_PER_BIT - 1);
  localparam logic [2:0] BIT_INDEX_MAX = 3'd7;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } state_t;

  state_t                     state;
  logic [CLK_COUNT_WIDTH-1:0] clk_count;
  logic [2:0]                 bit_index;
  // shifts right as bits go out
  logic [7:0]                 data_buffer;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      clk_count <= '0;
      bit_index <= '0;
      tx_ready  <= 1'b1;
      tx        <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          clk_count <= '0;
          bit_index <= '0;
          // start bit goes on the line at the accepting edge
          if (tx_en) begin
            data_buffer <= data;
            tx_ready    <= 1'b0;
            tx          <= 1'b0;
            state       <= START;
          end
        end

        START: begin
          if (clk_count < CLK_COUNT_MAX) begin
            clk_count <= clk_count + 1'b1;
          end else begin
            clk_count   <= '0;
            tx          <= data_buffer[0];
            data_buffer <= {1'b0, data_buffer[7:1]};
            state       <= DATA;
          end
        end

        DATA: begin
          if (clk_count < CLK_COUNT_MAX) begin
            clk_count <= clk_count + 1'b1;
          end else begin
            clk_count <= '0;
            if (bit_index < BIT_INDEX_MAX) begin
              bit_index   <= bit_index + 1'b1;
              tx          <= data_buffer[0];
              data_buffer <= {1'b0, data_buffer[7:1]};
            end else begin
              // last data bit done, drive the stop bit
              bit_index <= '0;
              tx        <= 1'b1;
              state     <= STOP;
            end
          end
        end

        STOP: begin
          if (clk_count < CLK_COUNT_MAX) begin
            clk_count <= clk_count + 1'b1;
          end else begin
            clk_count <= '0;
            tx_ready  <= 1'b1;
            state     <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_rx (
  input  logic               clk,
  input  logic               reset,
  input  logic               rx,
  output logic               rx_valid,
  output uart_pkg::rx_char_t rx_char
);
  localparam int CLOCKS_PER_BIT = `UART_CLOCK_FREQ / `UART_BAUD_RATE;
  localparam int CLK_COUNT_WIDTH = $clog2(CLOCKS_PER_BIT);

  localparam logic [CLK_COUNT_WIDTH-1:0] CLK_COUNT_MAX =
    CLK_COUNT_WIDTH'(CLOCKS_PER_BIT - 1);
  localparam logic [CLK_COUNT_WIDTH-1:0] CLK_COUNT_HALF =
    CLK_COUNT_WIDTH'(CLOCKS_PER_BIT / 2 - 1);
  localparam logic [2:0] BIT_INDEX_MAX = 3'd7;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } state_t;

  // two-flop synchronizer, then one more for edge detect
  logic                       rx_meta;
  logic                       rx_sync;
  logic                       rx_last;
  state_t                     state;
  logic [CLK_COUNT_WIDTH-1:0] clk_count;
  logic [2:0]                 bit_index;
  logic [7:0]                 shift_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      clk_count <= '0;
      bit_index <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          clk_count <= '0;
          bit_index <= '0;
          // wait for a falling edge, so a low stop bit does not restart
          if (!rx_sync && rx_last) begin
            state <= START;
          end
        end

        START: begin
          // half a bit to the start midpoint
          if (clk_count < CLK_COUNT_HALF) begin
            clk_count <= clk_count + 1'b1;
          end else begin
            clk_count <= '0;
            // high again at midpoint means a glitch
            state <= rx_sync ? IDLE : DATA;
          end
        end

        DATA: begin
          if (clk_count < CLK_COUNT_MAX) begin
            clk_count <= clk_count + 1'b1;
          end else begin
            clk_count <= '0;
            shift_reg <= {rx_sync, shift_reg[7:1]};
            if (bit_index < BIT_INDEX_MAX) begin
              bit_index <= bit_index + 1'b1;
            end else begin
              bit_index <= '0;
              state     <= STOP;
            end
          end
        end

        STOP: begin
          if (clk_count < CLK_COUNT_MAX) begin
            clk_count <= clk_count + 1'b1;
          end else begin
            // deliver even when badly framed
            clk_count         <= '0;
            rx_char.data      <= shift_reg;
            rx_char.frame_err <= !rx_sync;
            rx_valid          <= 1'b1;
            state             <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- uart_wb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_wb_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [1:0]         wb_adr,
  input  logic [7:0]         wb_dat_w,
  output logic [7:0]         wb_dat_r,
  output logic               wb_ack,
  output logic               tx_push,
  output logic [7:0]         tx_push_data,
  input  logic               tx_full,
  input  logic               tx_empty,
  output logic               rx_pop,
  input  uart_pkg::rx_char_t rx_head,
  input  logic               rx_empty,
  input  logic               rx_full,
  input  logic               rx_valid
);
  import uart_pkg::*;

  logic       req;
  logic       sel_data;
  logic       sel_status;
  logic       clr_frame_err;
  logic       clr_overrun;
  logic       frame_err;
  logic       overrun;
  logic [7:0] status;

  // first cycle of a transfer, the one that sets ack
  assign req = wb_cyc && wb_stb && !wb_ack;

  assign sel_data = wb_adr == `UART_ADDR_DATA;
  assign sel_status = wb_adr == `UART_ADDR_STATUS;

  // strobes only in the request cycle so each transfer acts once
  assign tx_push = req && wb_we && sel_data;
  assign tx_push_data = wb_dat_w;
  assign rx_pop = req && !wb_we && sel_data && !rx_empty;

  assign clr_frame_err = req && wb_we && sel_status && wb_dat_w[STATUS_FRAME_ERR];
  assign clr_overrun = req && wb_we && sel_status && wb_dat_w[STATUS_OVERRUN];

  always_comb begin
    status = '0;
    status[STATUS_TX_EMPTY] = tx_empty;
    status[STATUS_TX_FULL] = tx_full;
    status[STATUS_RX_EMPTY] = rx_empty;
    status[STATUS_RX_FULL] = rx_full;
    status[STATUS_FRAME_ERR] = frame_err;
    status[STATUS_OVERRUN] = overrun;
  end

  // one-cycle ack, never back to back
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // read data captured with the head before the pop lands
  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      if (sel_data) begin
        wb_dat_r <= rx_empty ? 8'h00 : rx_head.data;
      end else if (sel_status) begin
        wb_dat_r <= status;
      end else begin
        wb_dat_r <= `UART_READ_NONE;
      end
    end
  end

  // sticky errors, a new event wins over a clear
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_err <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      if (rx_pop && rx_head.frame_err) begin
        frame_err <= 1'b1;
      end else if (clr_frame_err) begin
        frame_err <= 1'b0;
      end
      // character arriving at a full FIFO is lost
      if (rx_valid && rx_full) begin
        overrun <= 1'b1;
      end else if (clr_overrun) begin
        overrun <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- uart_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [1:0] wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic       wb_ack,
  input  logic       rx,
  output logic       tx
);
  import uart_pkg::*;

  logic       tx_push;
  logic [7:0] tx_push_data;
  logic [7:0] tx_head;
  logic       tx_full;
  logic       tx_empty;
  logic       tx_ready;
  logic       tx_en;
  logic       rx_valid;
  rx_char_t   rx_char;
  rx_char_t   rx_head;
  logic       rx_pop;
  logic       rx_full;
  logic       rx_empty;

  // pop into the transmitter only in its idle cycle
  assign tx_en = !tx_empty && tx_ready;

  uart_wb_regs u_wb_regs (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .tx_push(tx_push), .tx_push_data(tx_push_data),
    .tx_full(tx_full), .tx_empty(tx_empty),
    .rx_pop(rx_pop), .rx_head(rx_head), .rx_empty(rx_empty),
    .rx_full(rx_full), .rx_valid(rx_valid)
  );

  uart_fifo #(.payload_t(logic [7:0])) u_tx_fifo (
    .clk(clk), .reset(reset),
    .push(tx_push), .push_data(tx_push_data),
    .pop(tx_en), .head(tx_head), .full(tx_full), .empty(tx_empty)
  );

  uart_tx u_tx (
    .clk(clk), .reset(reset),
    .data(tx_head), .tx_en(tx_en), .tx_ready(tx_ready), .tx(tx)
  );

  // receiver writes straight into its FIFO
  uart_rx u_rx (
    .clk(clk), .reset(reset),
    .rx(rx), .rx_valid(rx_valid), .rx_char(rx_char)
  );

  uart_fifo #(.payload_t(rx_char_t)) u_rx_fifo (
    .clk(clk), .reset(reset),
    .push(rx_valid), .push_data(rx_char),
    .pop(rx_pop), .head(rx_head), .full(rx_full), .empty(rx_empty)
  );

endmodule

`default_nettype wire

//--- uart_tb_clk.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tb_clk #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset drops just after an edge, like every other tb input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- uart_checker.sv
`timescale 1ns/10ps
`default_nettype none

module uart_checker (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic tx
);

  // an ack answers a request seen on the edge before
  ack_after_request: assert property (
    @(posedge clk) disable iff (reset) wb_ack |-> $past(wb_cyc && wb_stb)
  ) else $error("wb_ack without cyc and stb in the cycle before");

  ack_single_cycle: assert property (
    @(posedge clk) disable iff (reset) wb_ack |=> !wb_ack
  ) else $error("wb_ack high in two consecutive cycles");

  // serial line idles high once reset has been applied
  tx_idle_after_reset: assert property (
    @(posedge clk) reset |=> tx
  ) else $error("tx not high in the cycle after reset");

endmodule

bind uart_top uart_checker u_checker (
  .clk(clk), .reset(reset),
  .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
  .tx(tx)
);

`default_nettype wire

//--- uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_tb;
  import uart_pkg::*;

  localparam int DEPTH = `UART_FIFO_DEPTH;
  localparam int BIT_CYCLES = `UART_CLOCK_FREQ / `UART_BAUD_RATE;
  localparam int NUM_FIXED = 6;
  localparam int NUM_ROWS = NUM_FIXED + 4;
  localparam int ACK_TIMEOUT = 10;
  localparam int LINE_TIMEOUT = 400;
  // counted in status reads, not cycles
  localparam int POLL_TIMEOUT = 1000;
  localparam int RESET_TIMEOUT = 20;

  logic       clk;
  logic       reset;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [1:0] wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic       wb_ack;
  logic       tx_line;
  logic       rx_line;
  logic       rx_drv;
  logic       use_loopback;
  int         seed = 88;

  // one row per character: byte, driver or loopback, bad stop, status after readback
  logic [7:0] row_byte [NUM_ROWS];
  logic       row_driver [NUM_ROWS];
  logic       row_bad_stop [NUM_ROWS];
  logic [7:0] row_status [NUM_ROWS];

  assign rx_line = use_loopback ? tx_line : rx_drv;

  uart_tb_clk u_clk (.clk(clk), .reset(reset));

  uart_top u_uart_top (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .rx(rx_line), .tx(tx_line)
  );

  function automatic logic [7:0] status_word(input logic tx_empty, input logic tx_full,
      input logic rx_empty, input logic rx_full, input logic frame_err, input logic overrun);
    logic [7:0] s;
    s = 8'h00;
    s[STATUS_TX_EMPTY] = tx_empty;
    s[STATUS_TX_FULL] = tx_full;
    s[STATUS_RX_EMPTY] = rx_empty;
    s[STATUS_RX_FULL] = rx_full;
    s[STATUS_FRAME_ERR] = frame_err;
    s[STATUS_OVERRUN] = overrun;
    return s;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check(input string name, input logic [7:0] got, input logic [7:0] expected);
    if (got !== expected) begin
      stop_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  task automatic set_row(input int i, input logic [7:0] data, input logic driver,
      input logic bad_stop);
    row_byte[i] = data;
    row_driver[i] = driver;
    row_bad_stop[i] = bad_stop;
    row_status[i] = status_word(1'b1, 1'b0, 1'b1, 1'b0, bad_stop, 1'b0);
  endtask

  task automatic fill_table;
    int rnd;
    set_row(0, 8'h55, 1'b0, 1'b0);
    set_row(1, 8'ha3, 1'b0, 1'b0);
    set_row(2, 8'h00, 1'b1, 1'b0);
    set_row(3, 8'hff, 1'b0, 1'b0);
    set_row(4, 8'h3c, 1'b1, 1'b1);
    set_row(5, 8'h81, 1'b1, 1'b0);
    // the rest are random loopback bytes
    for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
      rnd = $random(seed);
      set_row(i, rnd[7:0], 1'b0, 1'b0);
    end
  endtask

  // one classic transfer, request held until ack
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
      output logic [7:0] rdata);
    int waited;
    @(posedge clk);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    waited = 0;
    @(negedge clk);
    while (!wb_ack) begin
      if (waited == ACK_TIMEOUT) begin
        stop_run("bus transfer got no ack");
      end
      waited++;
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] adr, input logic [7:0] data);
    logic [7:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input logic [1:0] adr, output logic [7:0] data);
    bus_cycle(1'b0, adr, 8'h00, data);
  endtask

  task automatic wait_status_bit(input int pos, input logic level, input string what);
    logic [7:0] st;
    int polls;
    polls = 0;
    bus_read(`UART_ADDR_STATUS, st);
    while (st[pos] !== level) begin
      if (polls == POLL_TIMEOUT) begin
        stop_run({"status never showed the expected ", what});
      end
      polls++;
      bus_read(`UART_ADDR_STATUS, st);
    end
  endtask

  task automatic select_line(input logic loopback);
    @(posedge clk);
    #2;
    use_loopback = loopback;
  endtask

  // start bit, 8 data bits lsb first, stop bit, then one idle bit
  task automatic send_serial(input logic [7:0] data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      rx_drv = frame[i];
      repeat (BIT_CYCLES - 1) @(posedge clk);
    end
    @(posedge clk);
    #2;
    rx_drv = 1'b1;
    repeat (BIT_CYCLES) @(posedge clk);
  endtask

  // samples tx at each bit midpoint, counted from the start edge
  task automatic watch_frame(input logic [7:0] expected);
    logic [7:0] data;
    int waited;
    waited = 0;
    @(negedge clk);
    while (tx_line !== 1'b0) begin
      if (waited == LINE_TIMEOUT) begin
        stop_run("no start bit appeared on tx");
      end
      waited++;
      @(negedge clk);
    end
    repeat (BIT_CYCLES / 2) @(negedge clk);
    check("tx start bit", {7'b0, tx_line}, 8'h00);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge clk);
      data[i] = tx_line;
    end
    check("tx data", data, expected);
    repeat (BIT_CYCLES) @(negedge clk);
    check("tx stop bit", {7'b0, tx_line}, 8'h01);
  endtask

  initial begin
    logic [7:0] rd;
    logic [7:0] st;
    int waited;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 2'd0;
    wb_dat_w = 8'h00;
    rx_drv = 1'b1;
    use_loopback = 1'b0;
    fill_table();

    waited = 0;
    @(posedge clk);
    while (reset) begin
      if (waited == RESET_TIMEOUT) begin
        stop_run("reset never released");
      end
      waited++;
      @(posedge clk);
    end

    bus_read(`UART_ADDR_STATUS, st);
    check("status after reset", st, status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    check("tx after reset", {7'b0, tx_line}, 8'h01);

    for (int i = 0; i < NUM_ROWS; i++) begin
      select_line(!row_driver[i]);
      if (row_driver[i]) begin
        send_serial(row_byte[i], !row_bad_stop[i]);
      end else begin
        fork
          bus_write(`UART_ADDR_DATA, row_byte[i]);
          watch_frame(row_byte[i]);
        join
      end
      wait_status_bit(STATUS_RX_EMPTY, 1'b0, "received character");
      bus_read(`UART_ADDR_DATA, rd);
      check("rx data", rd, row_byte[i]);
      bus_read(`UART_ADDR_STATUS, st);
      check("status after readback", st, row_status[i]);
      if (row_bad_stop[i]) begin
        bus_write(`UART_ADDR_STATUS, status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
        bus_read(`UART_ADDR_STATUS, st);
        check("status after frame_err clear", st,
              status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
      end
    end

    // one character more than the receive FIFO holds
    select_line(1'b0);
    for (int i = 0; i <= DEPTH; i++) begin
      send_serial(row_byte[i], 1'b1);
    end
    wait_status_bit(STATUS_OVERRUN, 1'b1, "overrun flag");
    bus_read(`UART_ADDR_STATUS, st);
    check("status after overrun", st, status_word(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
    for (int i = 0; i < DEPTH; i++) begin
      bus_read(`UART_ADDR_DATA, rd);
      check("rx data after overrun", rd, row_byte[i]);
    end
    bus_write(`UART_ADDR_STATUS, status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    bus_read(`UART_ADDR_STATUS, st);
    check("status after overrun clear", st, status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

    // first byte goes to the transmitter, the next DEPTH fill the FIFO, the last is dropped
    for (int i = 0; i < DEPTH + 2; i++) begin
      bus_write(`UART_ADDR_DATA, row_byte[i]);
    end
    bus_read(`UART_ADDR_STATUS, st);
    check("status with full tx FIFO", st, status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
    wait_status_bit(STATUS_TX_EMPTY, 1'b1, "empty transmit FIFO");
    bus_read(`UART_ADDR_STATUS, st);
    check("status after tx drain", st, status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_wb_regs.sv
uart_top.sv
uart_tb_clk.sv
uart_checker.sv
uart_tb.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 -f compile.f \
		--top-module uart_tb --Mdir $(OBJ_DIR) -o uart_tb_sim
	./$(OBJ_DIR)/uart_tb_sim

clean:
	rm -rf $(OBJ_DIR)
